//--- src.f
ddr_app_pkg.sv
ddr_fifo.sv
axi_wr_channel.sv
axi_rd_channel.sv
app_cmd_arbiter.sv
model_ddr_app.sv
ddr_app_subsys.sv
tb_ddr_app_subsys.sv

//--- run_sim.sh
#!/bin/sh
# Builds the AXI to DDR app bridge testbench with Verilator and runs it.
# Exits non-zero when the build fails, the run fails or the log reports failure.

cd "$(dirname "$0")" || exit 1

verilator --binary --timing --assert -Wno-fatal \
    --top-module tb_ddr_app_subsys -f src.f -o sim_tb
status=$?
if [ $status -ne 0 ]; then
    echo "Verilator build failed with status $status"
    exit 1
fi

./obj_dir/sim_tb > sim.log 2>&1
status=$?
cat sim.log
if [ $status -ne 0 ]; then
    echo "Simulation exited with status $status"
    exit 1
fi

if grep -q "Some tests failed" sim.log; then
    exit 1
fi
exit 0

//--- tb_ddr_app_subsys.sv
/* Testbench for the AXI to DDR app bridge with LFSR stimulus, a reference memory,
   B and R checkers and a watchdog */
`timescale 1ns/1ps
module tb_ddr_app_subsys;
    import ddr_app_pkg::*;

    localparam int CLK_PERIOD = 100;
    localparam int MAX_BEATS  = 8;                      // Longest burst is len 7
    localparam int N_A        = 24;                     // Write then read back
    localparam int N_WR       = 40;                     // Last 16 run against reads
    localparam int N_MIX      = 40;                     // Reads issued by the end of phase two
    localparam int N_RD       = N_MIX + N_WR - N_A;     // Phase three reads the upper half back
    localparam int HALF       = MEM_WORDS / 2;          // Phase two writes the upper half
    localparam int WATCHDOG_CYCLES = CALIB_CYCLES + 40 + (N_WR + N_RD) * MAX_BEATS * 16;

    logic    clock;
    logic    rst_n;
    axi_ax_t aw;
    logic    aw_valid;
    logic    aw_ready;
    axi_w_t  w;
    logic    w_valid;
    logic    w_ready;
    axi_b_t  b;
    logic    b_valid;
    logic    b_ready;
    axi_ax_t ar;
    logic    ar_valid;
    logic    ar_ready;
    axi_r_t  r;
    logic    r_valid;
    logic    r_ready;
    logic    calib_complete;

    // ******************** Stimulus tables and reference memory
    int                wr_idx [N_WR];                   // First beat index of each burst
    int                wr_len [N_WR];
    logic [ID_W-1:0]   wr_id [N_WR];
    logic [DATA_W-1:0] wr_data [N_WR][MAX_BEATS];
    logic [STRB_W-1:0] wr_strb [N_WR][MAX_BEATS];
    int                rd_idx [N_RD];
    int                rd_len [N_RD];
    logic [ID_W-1:0]   rd_id [N_RD];
    logic [DATA_W-1:0] ref_mem [MEM_WORDS];
    logic [STRB_W-1:0] ref_vld [MEM_WORDS];             // Bytes that some write has set
    logic [31:0]       lfsr = 32'h72f8663d;
    int                b_cnt = 0;
    int                r_bursts = 0;
    int                r_beat = 0;
    int                calib_edges;
    int                err_data = 0;
    int                err_resp = 0;
    int                err_misc = 0;

    ddr_app_subsys u_ddr_app_subsys (.*);

    always #(CLK_PERIOD / 2) clock = ~clock;

    // Galois LFSR, x^32+x^22+x^2+x+1, one step per bit taken
    function automatic logic [31:0] rand_bits(input int n);
        logic [31:0] v;
        v = '0;
        for (int i = 0; i < n; i++) begin
            lfsr = lfsr[0] ? ((lfsr >> 1) ^ 32'h80200003) : (lfsr >> 1);
            v    = {v[30:0], lfsr[0]};
        end
        return v;
    endfunction

    task automatic gen_stimulus();
        int src;
        for (int a = 0; a < MEM_WORDS; a++) ref_vld[a] = '0;
        for (int n = 0; n < N_WR; n++) begin
            wr_len[n] = int'(rand_bits(3));
            wr_idx[n] = int'(rand_bits(10) % (HALF - MAX_BEATS));  // Never wraps the memory
            if (n >= N_A) wr_idx[n] += HALF;
            wr_id[n] = ID_W'(rand_bits(ID_W));
            for (int k = 0; k < MAX_BEATS; k++) begin
                for (int q = 0; q < DATA_W / 32; q++) wr_data[n][k][32*q +: 32] = rand_bits(32);
                wr_strb[n][k] = STRB_W'(rand_bits(STRB_W));
            end
        end
        // Early reads cover the lower half, written and answered before they start
        for (int n = 0; n < N_RD; n++) begin
            if (n < N_A) begin
                src = n;
            end else if (n < N_MIX) begin
                src = int'(rand_bits(5) % N_A);
            end else begin
                src = N_A + (n - N_MIX);                // One read per upper half burst
            end
            rd_idx[n] = wr_idx[src];
            rd_len[n] = wr_len[src];
            rd_id[n]  = ID_W'(rand_bits(ID_W));
        end
    endtask

    // ******************** Drivers, entered and left just after a rising edge
    task automatic send_aw(input int n);
        aw       = '{id: wr_id[n], addr: 32'(wr_idx[n] * 16), len: LEN_W'(wr_len[n])};
        aw_valid = 1'b1;
        do @(negedge clock); while (!aw_ready);         // Transfer on the coming edge
        @(posedge clock);
        #1 aw_valid = 1'b0;
    endtask

    task automatic send_w(input int n);
        for (int k = 0; k <= wr_len[n]; k++) begin
            w       = '{data: wr_data[n][k], strb: wr_strb[n][k], last: (k == wr_len[n])};
            w_valid = 1'b1;
            do @(negedge clock); while (!w_ready);
            @(posedge clock);
            #1;
        end
        w_valid = 1'b0;
    endtask

    task automatic send_ar(input int n);
        ar       = '{id: rd_id[n], addr: 32'(rd_idx[n] * 16), len: LEN_W'(rd_len[n])};
        ar_valid = 1'b1;
        do @(negedge clock); while (!ar_ready);
        @(posedge clock);
        #1 ar_valid = 1'b0;
    endtask

    // Ready about three cycles in four on each response channel
    always begin
        @(posedge clock);
        #1;
        b_ready = (rand_bits(2) != 0);
        r_ready = (rand_bits(2) != 0);
    end

    // ******************** Checkers
    task automatic apply_write(input int n);
        int a;
        for (int k = 0; k <= wr_len[n]; k++) begin
            a = wr_idx[n] + k;
            for (int i = 0; i < STRB_W; i++) begin
                if (wr_strb[n][k][i]) begin
                    ref_mem[a][8*i +: 8] = wr_data[n][k][8*i +: 8];
                    ref_vld[a][i]        = 1'b1;
                end
            end
        end
    endtask

    task automatic check_r_beat(input int n, input int k);
        int a;
        a = rd_idx[n] + k;
        assert (r.id == rd_id[n]) else begin
            err_resp++;
            $display("ERR %0t r.id got %h exp %h", $time, r.id, rd_id[n]);
        end
        assert (r.last == (k == rd_len[n])) else begin
            err_resp++;
            $display("ERR %0t r.last got %b exp %b", $time, r.last, (k == rd_len[n]));
        end
        for (int i = 0; i < STRB_W; i++) begin
            assert (!ref_vld[a][i] || r.data[8*i +: 8] == ref_mem[a][8*i +: 8]) else begin
                err_data++;
                $display("ERR %0t r.data beat %0d byte %0d got %h exp %h",
                         $time, a, i, r.data[8*i +: 8], ref_mem[a][8*i +: 8]);
            end
        end
    endtask

    always @(posedge clock) begin
        if (!rst_n) calib_edges <= 0;
        else if (calib_edges <= CALIB_CYCLES) calib_edges <= calib_edges + 1;
    end

    // All sampling at the falling edge, half a cycle clear of both drive and capture
    always @(negedge clock) begin
        if (rst_n) begin
            assert (calib_complete == (calib_edges >= CALIB_CYCLES)) else begin
                err_misc++;
                $display("ERR %0t calib_complete got %b exp %b",
                         $time, calib_complete, (calib_edges >= CALIB_CYCLES));
            end
            assert (calib_complete || !(b_valid || r_valid)) else begin
                err_misc++;
                $display("A response was valid before calibration completed at %0t", $time);
            end
            if (b_valid && b_ready) begin
                assert (b_cnt < N_WR) else begin
                    err_misc++;
                    $display("A B response arrived with no write burst outstanding");
                end
                if (b_cnt < N_WR) begin
                    assert (b.id == wr_id[b_cnt]) else begin
                        err_resp++;
                        $display("ERR %0t b.id got %h exp %h", $time, b.id, wr_id[b_cnt]);
                    end
                    apply_write(b_cnt);                 // Writes land in B order
                end
                b_cnt++;
            end
            if (r_valid && r_ready) begin
                assert (r_bursts < N_RD) else begin
                    err_misc++;
                    $display("An R beat arrived with no read burst outstanding");
                end
                if (r_bursts < N_RD) begin
                    check_r_beat(r_bursts, r_beat);
                    if (r_beat == rd_len[r_bursts]) begin
                        r_beat = 0;
                        r_bursts++;
                    end else begin
                        r_beat++;
                    end
                end
            end
        end
    end

    // ******************** Sequence
    initial begin
        clock    = 1'b0;
        rst_n    = 1'b0;
        aw       = '0;
        aw_valid = 1'b0;
        w        = '0;
        w_valid  = 1'b0;
        b_ready  = 1'b0;
        ar       = '0;
        ar_valid = 1'b0;
        r_ready  = 1'b0;
        gen_stimulus();
        repeat (10) @(posedge clock);
        #1 rst_n = 1'b1;
        @(negedge clock);
        assert (aw_ready && ar_ready && !w_ready && !b_valid && !r_valid) else begin
            err_misc++;
            $display("Handshake outputs were wrong right after reset");
        end
        @(posedge clock);
        #1;
        // Random write bursts, then read every one of them back
        fork
            for (int n = 0; n < N_A; n++) send_aw(n);
            for (int n = 0; n < N_A; n++) send_w(n);
        join
        wait (b_cnt >= N_A);
        @(posedge clock);
        #1;
        for (int n = 0; n < N_A; n++) send_ar(n);
        wait (r_bursts >= N_A);
        @(posedge clock);
        #1;
        // Upper half writes run against lower half reads
        fork
            for (int n = N_A; n < N_WR; n++) send_aw(n);
            for (int n = N_A; n < N_WR; n++) send_w(n);
            for (int n = N_A; n < N_MIX; n++) send_ar(n);
        join
        wait (b_cnt >= N_WR && r_bursts >= N_MIX);
        @(posedge clock);
        #1;
        // Upper half read back once all its B responses are in
        for (int n = N_MIX; n < N_RD; n++) send_ar(n);
        wait (r_bursts >= N_RD);
        repeat (20) @(posedge clock);                   // Catches stray extra responses
        assert (b_cnt == N_WR && r_bursts == N_RD && r_beat == 0) else begin
            err_misc++;
            $display("Response counts did not match the bursts that were sent");
        end
        $display("Errors: data %0d, response %0d, other %0d", err_data, err_resp, err_misc);
        if (err_data + err_resp + err_misc == 0) begin
            $display("All tests passed");
        end else begin
            $display("Some tests failed");
        end
        $finish;
    end

    initial begin
        #(WATCHDOG_CYCLES * CLK_PERIOD);
        $display("Watchdog expired with %0d of %0d B and %0d of %0d R bursts done",
                 b_cnt, N_WR, r_bursts, N_RD);
        $display("Some tests failed");
        $finish;
    end

endmodule

//--- ddr_app_subsys.sv
/* Top level, AXI write and read channels, command arbiter and controller model */
`timescale 1ns/1ps
module ddr_app_subsys (
    input  logic                 clock,
    input  logic                 rst_n,
    input  ddr_app_pkg::axi_ax_t aw,
    input  logic                 aw_valid,
    output logic                 aw_ready,
    input  ddr_app_pkg::axi_w_t  w,
    input  logic                 w_valid,
    output logic                 w_ready,
    output ddr_app_pkg::axi_b_t  b,
    output logic                 b_valid,
    input  logic                 b_ready,
    input  ddr_app_pkg::axi_ax_t ar,
    input  logic                 ar_valid,
    output logic                 ar_ready,
    output ddr_app_pkg::axi_r_t  r,
    output logic                 r_valid,
    input  logic                 r_ready,
    output logic                 calib_complete
);
    import ddr_app_pkg::*;

    // ******************** Beat requests
    app_wr_req_t       wr_req;
    logic              wr_req_valid;
    logic              wr_req_ready;
    app_rd_req_t       rd_req;
    logic              rd_req_valid;
    logic              rd_req_ready;

    // ******************** Native app interface
    logic [ADDR_W-1:0] app_addr;
    logic [CMD_W-1:0]  app_cmd;
    logic              app_en;
    logic [DATA_W-1:0] app_wdf_data;
    logic [STRB_W-1:0] app_wdf_mask;
    logic              app_wdf_wren;
    logic              app_wdf_end;
    logic [DATA_W-1:0] app_rd_data;
    logic              app_rd_data_valid;
    logic              app_rdy;
    logic              app_wdf_rdy;

    axi_wr_channel u_wr (
        .clock        (clock),
        .rst_n        (rst_n),
        .aw           (aw),
        .aw_valid     (aw_valid),
        .aw_ready     (aw_ready),
        .w            (w),
        .w_valid      (w_valid),
        .w_ready      (w_ready),
        .b            (b),
        .b_valid      (b_valid),
        .b_ready      (b_ready),
        .wr_req       (wr_req),
        .wr_req_valid (wr_req_valid),
        .wr_req_ready (wr_req_ready)
    );

    axi_rd_channel u_rd (
        .clock             (clock),
        .rst_n             (rst_n),
        .ar                (ar),
        .ar_valid          (ar_valid),
        .ar_ready          (ar_ready),
        .r                 (r),
        .r_valid           (r_valid),
        .r_ready           (r_ready),
        .rd_req            (rd_req),
        .rd_req_valid      (rd_req_valid),
        .rd_req_ready      (rd_req_ready),
        .app_rd_data       (app_rd_data),
        .app_rd_data_valid (app_rd_data_valid)
    );

    app_cmd_arbiter u_arb (
        .clock        (clock),
        .rst_n        (rst_n),
        .wr_req       (wr_req),
        .wr_req_valid (wr_req_valid),
        .wr_req_ready (wr_req_ready),
        .rd_req       (rd_req),
        .rd_req_valid (rd_req_valid),
        .rd_req_ready (rd_req_ready),
        .app_addr     (app_addr),
        .app_cmd      (app_cmd),
        .app_en       (app_en),
        .app_wdf_data (app_wdf_data),
        .app_wdf_mask (app_wdf_mask),
        .app_wdf_wren (app_wdf_wren),
        .app_wdf_end  (app_wdf_end),
        .app_rdy      (app_rdy),
        .app_wdf_rdy  (app_wdf_rdy)
    );

    model_ddr_app u_model (
        .clock               (clock),
        .rst_n               (rst_n),
        .app_addr            (app_addr),
        .app_cmd             (app_cmd),
        .app_en              (app_en),
        .app_wdf_data        (app_wdf_data),
        .app_wdf_end         (app_wdf_end),
        .app_wdf_mask        (app_wdf_mask),
        .app_wdf_wren        (app_wdf_wren),
        .app_rd_data         (app_rd_data),
        .app_rd_data_end     (),                        // Same as valid for single-beat reads
        .app_rd_data_valid   (app_rd_data_valid),
        .app_rdy             (app_rdy),
        .app_wdf_rdy         (app_wdf_rdy),
        .init_calib_complete (calib_complete)
    );

endmodule

//--- model_ddr_app.sv
/* Cycle-level DDR controller app model with calibration, refresh stalls,
   byte-masked memory and a fixed read latency */
`timescale 1ns/1ps
module model_ddr_app (
    input  logic                            clock,
    input  logic                            rst_n,
    input  logic [ddr_app_pkg::ADDR_W-1:0]  app_addr,
    input  logic [ddr_app_pkg::CMD_W-1:0]   app_cmd,
    input  logic                            app_en,
    input  logic [ddr_app_pkg::DATA_W-1:0]  app_wdf_data,
    input  logic                            app_wdf_end,
    input  logic [ddr_app_pkg::STRB_W-1:0]  app_wdf_mask,
    input  logic                            app_wdf_wren,
    output logic [ddr_app_pkg::DATA_W-1:0]  app_rd_data,
    output logic                            app_rd_data_end,
    output logic                            app_rd_data_valid,
    output logic                            app_rdy,
    output logic                            app_wdf_rdy,
    output logic                            init_calib_complete
);
    import ddr_app_pkg::*;

    logic [CALIB_W-1:0]   calib_cnt;                    // Saturates at CALIB_CYCLES
    logic [REF_W-1:0]     ref_cnt;
    logic [DATA_W-1:0]    mem [MEM_WORDS];
    logic [MEM_IDX_W-1:0] idx;
    logic                 wr_fire;
    logic                 rd_fire;
    logic [DATA_W-1:0]    rd_pipe [RD_LAT];             // Read data in flight
    logic [RD_LAT-1:0]    rd_vld_pipe;

    // ******************** Calibration and refresh
    assign init_calib_complete = (calib_cnt == CALIB_W'(CALIB_CYCLES));
    assign app_rdy             = init_calib_complete && (ref_cnt != REF_W'(REF_PERIOD - 1));
    assign app_wdf_rdy         = init_calib_complete;   // Write data path never stalls

    always_ff @(posedge clock) begin
        if (!rst_n) begin
            calib_cnt <= '0;
            ref_cnt   <= '0;
        end else begin
            if (!init_calib_complete) calib_cnt <= calib_cnt + 1'b1;
            ref_cnt <= ref_cnt + 1'b1;                  // Wraps once per refresh period
        end
    end

    // ******************** Command decode
    assign idx     = app_addr[BEAT_SHIFT +: MEM_IDX_W]; // Beat index modulo MEM_WORDS
    assign wr_fire = app_en && app_rdy && (app_cmd == CMD_WR)
                     && app_wdf_wren && app_wdf_end && app_wdf_rdy;
    assign rd_fire = app_en && app_rdy && (app_cmd == CMD_RD);

    // Byte lanes with their mask bit set keep the old contents
    always_ff @(posedge clock) begin
        if (wr_fire) begin
            for (int i = 0; i < STRB_W; i++) begin
                if (!app_wdf_mask[i]) mem[idx][8*i +: 8] <= app_wdf_data[8*i +: 8];
            end
        end
    end

    // ******************** Read latency pipeline
    always_ff @(posedge clock) begin
        rd_pipe[0] <= mem[idx];                         // Only valid stages are ever used
        for (int s = 1; s < RD_LAT; s++) begin
            rd_pipe[s] <= rd_pipe[s-1];
        end
    end

    always_ff @(posedge clock) begin
        if (!rst_n) begin
            rd_vld_pipe <= '0;
        end else begin
            rd_vld_pipe <= {rd_vld_pipe[RD_LAT-2:0], rd_fire};
        end
    end

    assign app_rd_data       = rd_pipe[RD_LAT-1];
    assign app_rd_data_valid = rd_vld_pipe[RD_LAT-1];
    assign app_rd_data_end   = rd_vld_pipe[RD_LAT-1];   // One beat per command

endmodule

//--- app_cmd_arbiter.sv
/* Round-robin arbiter between write and read beats onto the native command port */
`timescale 1ns/1ps
module app_cmd_arbiter (
    input  logic                            clock,
    input  logic                            rst_n,
    input  ddr_app_pkg::app_wr_req_t        wr_req,
    input  logic                            wr_req_valid,
    output logic                            wr_req_ready,
    input  ddr_app_pkg::app_rd_req_t        rd_req,
    input  logic                            rd_req_valid,
    output logic                            rd_req_ready,
    output logic [ddr_app_pkg::ADDR_W-1:0]  app_addr,
    output logic [ddr_app_pkg::CMD_W-1:0]   app_cmd,
    output logic                            app_en,
    output logic [ddr_app_pkg::DATA_W-1:0]  app_wdf_data,
    output logic [ddr_app_pkg::STRB_W-1:0]  app_wdf_mask,
    output logic                            app_wdf_wren,
    output logic                            app_wdf_end,
    input  logic                            app_rdy,
    input  logic                            app_wdf_rdy
);
    import ddr_app_pkg::*;

    logic rr_rd;                                        // High gives reads priority
    logic grant_wr;
    logic grant_rd;

    // ******************** Grant
    assign grant_wr = wr_req_valid && (!rd_req_valid || !rr_rd);
    assign grant_rd = rd_req_valid && !grant_wr;

    // A write needs both the command and the write data path
    assign wr_req_ready = grant_wr && app_rdy && app_wdf_rdy;
    assign rd_req_ready = grant_rd && app_rdy;

    // ******************** Native outputs
    assign app_en       = grant_wr || grant_rd;
    assign app_cmd      = grant_wr ? CMD_WR : CMD_RD;
    assign app_addr     = grant_wr ? wr_req.addr : rd_req.addr;
    assign app_wdf_data = wr_req.data;
    assign app_wdf_mask = wr_req.mask;
    assign app_wdf_wren = grant_wr;
    assign app_wdf_end  = grant_wr;                     // Every write is a single beat

    // Pointer flips only when both sides competed and one was served
    always_ff @(posedge clock) begin
        if (!rst_n) begin
            rr_rd <= 1'b0;
        end else if (wr_req_valid && rd_req_valid && (wr_req_ready || rd_req_ready)) begin
            rr_rd <= !rr_rd;
        end
    end

endmodule

//--- axi_rd_channel.sv
/* AXI read channel, credit-limited beat requests, an in-order tag queue and
   the R data buffer */
`timescale 1ns/1ps
module axi_rd_channel (
    input  logic                             clock,
    input  logic                             rst_n,
    input  ddr_app_pkg::axi_ax_t             ar,
    input  logic                             ar_valid,
    output logic                             ar_ready,
    output ddr_app_pkg::axi_r_t              r,
    output logic                             r_valid,
    input  logic                             r_ready,
    output ddr_app_pkg::app_rd_req_t         rd_req,
    output logic                             rd_req_valid,
    input  logic                             rd_req_ready,
    input  logic [ddr_app_pkg::DATA_W-1:0]   app_rd_data,
    input  logic                             app_rd_data_valid
);
    import ddr_app_pkg::*;

    logic              busy;                            // Burst still issuing beats
    logic [ADDR_W-1:0] cur_addr;
    logic [ID_W-1:0]   cur_id;
    logic [LEN_W-1:0]  beats_left;                      // Beats after the current one
    logic [FIFO_PTR_W:0] credits;                       // Beats issued and not yet popped as R
    logic              req_fire;
    logic              r_fire;
    rd_beat_t          tag_in;
    rd_beat_t          tag_head;
    rd_beat_t          beat_in;
    rd_beat_t          beat_out;

    assign ar_ready     = !busy;
    assign rd_req_valid = busy && (credits != FIFO_DEPTH);  // A data FIFO slot is reserved
    assign rd_req       = '{addr: cur_addr};
    assign req_fire     = rd_req_valid && rd_req_ready;
    assign r_fire       = r_valid && r_ready;

    // ******************** Tag queue
    // Tags carry no data, only the id and last flag for each issued beat
    assign tag_in = '{id: cur_id, data: '0, last: (beats_left == '0)};

    ddr_fifo #(
        .payload_t (rd_beat_t)
    ) u_tag_fifo (
        .clock     (clock),
        .rst_n     (rst_n),
        .in_data   (tag_in),
        .in_valid  (req_fire),
        .in_ready  (),                                  // Credits bound the tag count too
        .out_data  (tag_head),
        .out_valid (),
        .out_ready (app_rd_data_valid)                  // One tag per returned beat
    );

    // ******************** Data buffer
    assign beat_in = '{id: tag_head.id, data: app_rd_data, last: tag_head.last};

    ddr_fifo #(
        .payload_t (rd_beat_t)
    ) u_data_fifo (
        .clock     (clock),
        .rst_n     (rst_n),
        .in_data   (beat_in),
        .in_valid  (app_rd_data_valid),
        .in_ready  (),                                  // Never full when data returns
        .out_data  (beat_out),
        .out_valid (r_valid),
        .out_ready (r_ready)
    );

    assign r = '{id: beat_out.id, data: beat_out.data, last: beat_out.last};

    // ******************** Burst splitter and credits
    always_ff @(posedge clock) begin
        if (!rst_n) begin
            busy    <= 1'b0;
            credits <= '0;
        end else begin
            if (ar_valid && ar_ready) busy <= 1'b1;
            else if (req_fire && beats_left == '0) busy <= 1'b0;
            case ({req_fire, r_fire})
                2'b10:   credits <= credits + 1'b1;
                2'b01:   credits <= credits - 1'b1;
                default: credits <= credits;
            endcase
        end
    end

    always_ff @(posedge clock) begin
        if (ar_valid && ar_ready) begin
            cur_addr   <= ar.addr[ADDR_W:1];            // Native address is byte address over two
            cur_id     <= ar.id;
            beats_left <= ar.len;
        end else if (req_fire) begin
            cur_addr   <= cur_addr + ADDR_W'(BEAT_STEP);
            beats_left <= beats_left - 1'b1;
        end
    end

endmodule

//--- axi_wr_channel.sv
/* AXI write channel, splits AW/W bursts into native write beats and returns B */
`timescale 1ns/1ps
module axi_wr_channel (
    input  logic                     clock,
    input  logic                     rst_n,
    input  ddr_app_pkg::axi_ax_t     aw,
    input  logic                     aw_valid,
    output logic                     aw_ready,
    input  ddr_app_pkg::axi_w_t      w,
    input  logic                     w_valid,
    output logic                     w_ready,
    output ddr_app_pkg::axi_b_t      b,
    output logic                     b_valid,
    input  logic                     b_ready,
    output ddr_app_pkg::app_wr_req_t wr_req,
    output logic                     wr_req_valid,
    input  logic                     wr_req_ready
);
    import ddr_app_pkg::*;

    axi_ax_t           aw_head;                         // Oldest queued burst
    logic              aw_head_valid;
    logic              aw_pop;
    logic              active;                          // A burst is being walked
    logic [ADDR_W-1:0] cur_addr;
    logic [ID_W-1:0]   cur_id;
    logic              beat_fire;

    // ******************** AW queue
    ddr_fifo #(
        .payload_t (axi_ax_t)
    ) u_aw_fifo (
        .clock     (clock),
        .rst_n     (rst_n),
        .in_data   (aw),
        .in_valid  (aw_valid),
        .in_ready  (aw_ready),
        .out_data  (aw_head),
        .out_valid (aw_head_valid),
        .out_ready (aw_pop)
    );

    // Next burst starts only once the previous B has been taken
    assign aw_pop = !active && !b_valid;

    // W beats pass straight through while a burst is active
    assign wr_req_valid = active && w_valid;
    assign w_ready      = active && wr_req_ready;
    assign wr_req       = '{addr: cur_addr, data: w.data, mask: ~w.strb};
    assign beat_fire    = wr_req_valid && wr_req_ready;
    assign b            = '{id: cur_id};

    // ******************** Burst engine
    always_ff @(posedge clock) begin
        if (!rst_n) begin
            active  <= 1'b0;
            b_valid <= 1'b0;
        end else begin
            if (aw_head_valid && aw_pop) begin
                active <= 1'b1;
            end else if (beat_fire && w.last) begin
                active  <= 1'b0;                        // Last beat taken by the arbiter
                b_valid <= 1'b1;
            end
            if (b_valid && b_ready) b_valid <= 1'b0;
        end
    end

    // Address and id carry no reset
    always_ff @(posedge clock) begin
        if (aw_head_valid && aw_pop) begin
            cur_addr <= aw_head.addr[ADDR_W:1];         // Byte address over two
            cur_id   <= aw_head.id;
        end else if (beat_fire) begin
            cur_addr <= cur_addr + ADDR_W'(BEAT_STEP);
        end
    end

endmodule

//--- ddr_fifo.sv
/* Synchronous valid/ready FIFO, circular buffer with a type parameter payload */
`timescale 1ns/1ps
module ddr_fifo #(
    parameter type payload_t = logic
) (
    input  logic     clock,
    input  logic     rst_n,
    input  payload_t in_data,
    input  logic     in_valid,
    output logic     in_ready,
    output payload_t out_data,
    output logic     out_valid,
    input  logic     out_ready
);
    import ddr_app_pkg::*;

    payload_t              mem [FIFO_DEPTH];            // Storage, no reset needed
    logic [FIFO_PTR_W-1:0] wr_ptr;
    logic [FIFO_PTR_W-1:0] rd_ptr;
    logic [FIFO_PTR_W:0]   count;                       // One extra bit to hold FIFO_DEPTH
    logic                  push;
    logic                  pop;

    assign in_ready  = (count != FIFO_DEPTH);           // Not full
    assign out_valid = (count != 0);                    // Not empty
    assign out_data  = mem[rd_ptr];                     // Head is always visible
    assign push      = in_valid && in_ready;
    assign pop       = out_valid && out_ready;

    // ******************** Pointers and count
    always_ff @(posedge clock) begin
        if (!rst_n) begin
            wr_ptr <= '0;
            rd_ptr <= '0;
            count  <= '0;
        end else begin
            if (push) wr_ptr <= wr_ptr + 1'b1;          // Depth is a power of two so it wraps
            if (pop) rd_ptr <= rd_ptr + 1'b1;
            case ({push, pop})
                2'b10:   count <= count + 1'b1;
                2'b01:   count <= count - 1'b1;
                default: count <= count;                // Both or neither leave it unchanged
            endcase
        end
    end

    always_ff @(posedge clock) begin
        if (push) mem[wr_ptr] <= in_data;
    end

endmodule

//--- ddr_app_pkg.sv
/* Widths, model timing constants, native command codes and the AXI and
   native request struct types of the AXI to DDR app bridge */
package ddr_app_pkg;

    // ******************** Widths
    localparam int ADDR_W = 29;                         // Native app_addr width
    localparam int DATA_W = 128;                        // One full-width beat
    localparam int STRB_W = DATA_W / 8;                 // Byte lanes per beat
    localparam int ID_W   = 4;
    localparam int LEN_W  = 8;
    localparam int CMD_W  = 3;                          // Width of app_cmd

    // ******************** Native addressing
    localparam int BEAT_STEP  = 8;                      // Native units per 16 byte beat
    localparam int BEAT_SHIFT = $clog2(BEAT_STEP);
    localparam int MEM_WORDS  = 1024;                   // Model depth in beats
    localparam int MEM_IDX_W  = $clog2(MEM_WORDS);

    // ******************** Model timing
    localparam int CALIB_CYCLES = 64;
    localparam int CALIB_W      = $clog2(CALIB_CYCLES + 1);
    localparam int RD_LAT       = 4;                    // Command taken to data valid
    localparam int REF_PERIOD   = 16;                   // One stall cycle per period
    localparam int REF_W        = $clog2(REF_PERIOD);

    // ******************** FIFO sizing
    localparam int FIFO_DEPTH = 8;
    localparam int FIFO_PTR_W = $clog2(FIFO_DEPTH);

    // Native command codes as seen on app_cmd
    localparam logic [CMD_W-1:0] CMD_WR = 3'd0;
    localparam logic [CMD_W-1:0] CMD_RD = 3'd1;

    // Address channel, shared by AW and AR
    typedef struct packed {
        logic [ID_W-1:0]  id;
        logic [31:0]      addr;                         // AXI byte address
        logic [LEN_W-1:0] len;                          // Beats minus one
    } axi_ax_t;

    typedef struct packed {
        logic [DATA_W-1:0] data;
        logic [STRB_W-1:0] strb;
        logic              last;
    } axi_w_t;

    typedef struct packed {
        logic [ID_W-1:0] id;
    } axi_b_t;

    typedef struct packed {
        logic [ID_W-1:0]   id;
        logic [DATA_W-1:0] data;
        logic              last;
    } axi_r_t;

    // One native write beat, mask bit high skips that byte
    typedef struct packed {
        logic [ADDR_W-1:0] addr;
        logic [DATA_W-1:0] data;
        logic [STRB_W-1:0] mask;
    } app_wr_req_t;

    typedef struct packed {
        logic [ADDR_W-1:0] addr;
    } app_rd_req_t;

    // Read data tagged for in-order return inside the read channel
    typedef struct packed {
        logic [ID_W-1:0]   id;
        logic [DATA_W-1:0] data;
        logic              last;
    } rd_beat_t;

endpackage
